//--- vec_lane.f
+incdir+hdl
hdl/vec_data_pkg.sv
hdl/vec_isa_pkg.sv
hdl/stream_fifo.sv
hdl/vec_regfile.sv
hdl/vec_mac_pe.sv
hdl/vec_sequencer.sv
hdl/vec_lane_top.sv
test/vec_lane_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the vector lane testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    -Mdir obj_dir \
    --top-module vec_lane_tb \
    -f vec_lane.f

./obj_dir/Vvec_lane_tb | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "simulation ended without a result line, see $LOG"
    exit 1
fi

//--- test/vec_lane_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "vec_lane_config.svh"

module vec_lane_tb
    import vec_data_pkg::*, vec_isa_pkg::*;
();
    localparam int EW             = `VL_ELEM_W;
    localparam int LANES          = `VL_LANES;
    localparam int TIMEOUT_CYCLES = 20000;  // 6 tests x ~6 instr x 16 elem x 4 cycles, plus margin

    logic     clk = 1'b0;
    logic     rst;
    logic     i_start;
    opcode_t  i_opcode;
    rf_addr_t i_vd;
    rf_addr_t i_vs;
    vlen_t    i_vl;
    phit_t    i_in_data;
    logic     i_in_valid;
    logic     o_in_ready;
    phit_t    o_out_data;
    logic     o_out_last;
    logic     o_out_valid;
    logic     i_out_ready;
    logic     o_steady;
    logic     o_instr_done;
    logic     o_ap_done;

    phit_t model_rf [`VL_RF_DEPTH];  // expected register contents
    phit_t model_in[$];              // input phits not yet consumed by the model
    phit_t src_q[$];                 // input phits not yet offered to the DUT
    phit_t exp_data[$];
    logic  exp_last[$];
    string exp_name[$];              // test that produced each expected beat
    string test_name;
    logic  bp_mode = 1'b0;
    int    err_main;
    int    err_sink;
    int    err_mon;
    int    beats;
    int    done_seen;
    int    ap_seen;
    int    instr_sent;

    always #5 clk = ~clk;

    vec_lane_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_start      (i_start),
        .i_opcode     (i_opcode),
        .i_vd         (i_vd),
        .i_vs         (i_vs),
        .i_vl         (i_vl),
        .i_in_data    (i_in_data),
        .i_in_valid   (i_in_valid),
        .o_in_ready   (o_in_ready),
        .o_out_data   (o_out_data),
        .o_out_last   (o_out_last),
        .o_out_valid  (o_out_valid),
        .i_out_ready  (i_out_ready),
        .o_steady     (o_steady),
        .o_instr_done (o_instr_done),
        .o_ap_done    (o_ap_done)
    );

    // reference model, element k of a register is row base + k mod depth
    function automatic void apply_instr(opcode_t op, rf_addr_t vd, rf_addr_t vs, vlen_t vl);
        phit_t    in_p;
        phit_t    res;
        elem_t    acc;
        elem_t    mul;
        elem_t    x;
        rf_addr_t rd;
        rf_addr_t rs;
        for (int k = 0; k < int'(vl); k++) begin
            rd = vd + rf_addr_t'(k);
            rs = vs + rf_addr_t'(k);
            case (op)
                OP_VLOAD:  model_rf[rd] = model_in.pop_front();
                OP_VCLEAR: model_rf[rd] = '0;
                OP_VMACC: begin
                    in_p = model_in.pop_front();
                    for (int l = 0; l < LANES; l++) begin
                        acc = model_rf[rd][l*EW +: EW];
                        mul = model_rf[rs][l*EW +: EW];
                        x   = in_p[l*EW +: EW];
                        res[l*EW +: EW] = acc + x * mul;  // wraps at element width
                    end
                    model_rf[rd] = res;
                end
                OP_VSTREAMOUT: begin
                    exp_data.push_back(model_rf[rd]);
                    exp_last.push_back(k == int'(vl) - 1);
                    exp_name.push_back(test_name);
                end
                default: ;
            endcase
        end
    endfunction

    function automatic phit_t rand_phit();
        phit_t p;
        for (int l = 0; l < LANES; l++) begin
            p[l*EW +: EW] = elem_t'($urandom);
        end
        return p;
    endfunction

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            err_main++;
            $display("Fail %s %s expected %0b actual %0b", test_name, what, exp, act);
        end
    endtask

    task automatic feed_phit(phit_t p);
        src_q.push_back(p);
        model_in.push_back(p);
    endtask

    // ends one cycle after the start pulse, with the sequencer in fetch
    task automatic start_lane();
        @(posedge clk);
        #1;
        i_start = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
    endtask

    // called in the fetch cycle, returns in the next fetch cycle
    task automatic run_instr(opcode_t op, rf_addr_t vd, rf_addr_t vs, vlen_t vl);
        apply_instr(op, vd, vs, vl);
        instr_sent++;
        i_opcode = op;
        i_vd     = vd;
        i_vs     = vs;
        i_vl     = vl;
        do begin
            @(negedge clk);
        end while (!o_instr_done);
        @(posedge clk);
        #1;
    endtask

    task automatic run_halt();
        i_opcode = OP_HALT;
        do begin
            @(negedge clk);
        end while (!o_ap_done);
        check_bit("o_steady after halt", 1'b0, o_steady);
        check_bit("o_in_ready after halt", 1'b0, o_in_ready);
        @(negedge clk);
        check_bit("o_ap_done a cycle after halt", 1'b0, o_ap_done);
        check_bit("o_steady stays low", 1'b0, o_steady);
        @(posedge clk);
        #1;
    endtask

    task automatic check_done_count();
        if (done_seen != instr_sent) begin
            err_main++;
            $display("Fail %s instr_done count expected %0d actual %0d",
                     test_name, instr_sent, done_seen);
        end
    endtask

    task automatic clear_program();
        vlen_t    vl;
        rf_addr_t vd;
        vl = vlen_t'(1 + $urandom % 16);
        vd = rf_addr_t'($urandom % 16);
        run_instr(OP_VCLEAR, vd, vd, vl);
        run_instr(OP_VSTREAMOUT, vd, vd, vl);
    endtask

    task automatic load_program();
        vlen_t    vl;
        rf_addr_t vd;
        vl = vlen_t'(1 + $urandom % 16);
        vd = rf_addr_t'($urandom % 16);
        repeat (vl) feed_phit(rand_phit());
        run_instr(OP_VLOAD, vd, vd, vl);
        run_instr(OP_VSTREAMOUT, vd, vd, vl);
    endtask

    // vs rows always wrap past the top of the file, vd sits 8 rows away
    task automatic macc_program();
        vlen_t    vl;
        rf_addr_t vs;
        rf_addr_t vd;
        vl = vlen_t'(7 + $urandom % 2);
        vs = rf_addr_t'(10 + $urandom % 6);
        vd = vs + rf_addr_t'(8);
        repeat (vl) feed_phit(rand_phit());
        run_instr(OP_VLOAD, vs, vs, vl);
        repeat (vl) feed_phit(rand_phit());
        run_instr(OP_VLOAD, vd, vs, vl);
        repeat (vl) feed_phit(rand_phit());
        run_instr(OP_VMACC, vd, vs, vl);
        run_instr(OP_VSTREAMOUT, vd, vs, vl);
    endtask

    // input stream source, an offered beat stays up until taken
    initial begin : source
        logic taken;
        taken      = 1'b0;
        i_in_valid = 1'b0;
        i_in_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (taken) begin
                i_in_valid = 1'b0;
                taken      = 1'b0;
            end
            if (!i_in_valid && src_q.size() > 0) begin
                if (!bp_mode || ($urandom % 3) != 0) begin  // gaps under back-pressure
                    i_in_data  = src_q.pop_front();
                    i_in_valid = 1'b1;
                end
            end
            @(negedge clk);
            if (i_in_valid && o_in_ready) begin
                taken = 1'b1;
            end
        end
    end

    // output stream sink and checker
    initial begin : sink
        logic  held;
        phit_t held_data;
        logic  held_last;
        phit_t want_data;
        logic  want_last;
        string want_name;
        held        = 1'b0;
        held_data   = '0;
        held_last   = 1'b0;
        i_out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            i_out_ready = !bp_mode || (($urandom % 2) == 0);
            @(negedge clk);
            if (!rst) begin
                if (held) begin  // stalled beat from last cycle
                    if (!o_out_valid) begin
                        err_sink++;
                        $display("output valid dropped before its beat was taken");
                    end
                    if (o_out_data !== held_data) begin
                        err_sink++;
                        $display("Fail %s held data expected %h actual %h",
                                 test_name, held_data, o_out_data);
                    end
                    if (o_out_last !== held_last) begin
                        err_sink++;
                        $display("Fail %s held last expected %0b actual %0b",
                                 test_name, held_last, o_out_last);
                    end
                end
                if (o_out_valid && i_out_ready) begin
                    if (exp_data.size() == 0) begin
                        err_sink++;
                        $display("output beat arrived with nothing expected in %s", test_name);
                    end else begin
                        want_data = exp_data.pop_front();
                        want_last = exp_last.pop_front();
                        want_name = exp_name.pop_front();
                        beats++;
                        if (o_out_data !== want_data) begin
                            err_sink++;
                            $display("Fail %s data expected %h actual %h",
                                     want_name, want_data, o_out_data);
                        end
                        if (o_out_last !== want_last) begin
                            err_sink++;
                            $display("Fail %s last expected %0b actual %0b",
                                     want_name, want_last, o_out_last);
                        end
                    end
                end
                held      = o_out_valid && !i_out_ready;
                held_data = o_out_data;
                held_last = o_out_last;
            end
        end
    end

    // done pulses, counted and kept to one cycle
    initial begin : pulse_monitor
        logic done_prev;
        logic ap_prev;
        done_prev = 1'b0;
        ap_prev   = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (o_instr_done && done_prev) begin
                    err_mon++;
                    $display("o_instr_done stayed high for two cycles in %s", test_name);
                end
                if (o_ap_done && ap_prev) begin
                    err_mon++;
                    $display("o_ap_done stayed high for two cycles in %s", test_name);
                end
                if (o_instr_done) begin
                    done_seen++;
                end
                if (o_ap_done) begin
                    ap_seen++;
                end
            end
            done_prev = o_instr_done;
            ap_prev   = o_ap_done;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the program did not finish within %0d cycles", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        int err_total;
        void'($urandom(32'h3328));
        rst       = 1'b1;
        i_start   = 1'b0;
        i_opcode  = OP_VCLEAR;
        i_vd      = '0;
        i_vs      = '0;
        i_vl      = vlen_t'(1);
        test_name = "reset_state";
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_bit("o_steady", 1'b0, o_steady);
        check_bit("o_in_ready", 1'b0, o_in_ready);
        check_bit("o_out_valid", 1'b0, o_out_valid);
        check_bit("o_instr_done", 1'b0, o_instr_done);
        check_bit("o_ap_done", 1'b0, o_ap_done);
        start_lane();
        check_bit("o_steady after start", 1'b1, o_steady);
        check_bit("o_in_ready after start", 1'b1, o_in_ready);

        // instructions follow back to back, fetch has no idle state
        test_name = "clear_stream";
        clear_program();
        check_done_count();

        test_name = "load_roundtrip";
        load_program();
        check_done_count();

        test_name = "macc_lanes";
        macc_program();
        check_done_count();

        test_name = "backpressure";
        bp_mode = 1'b1;
        macc_program();
        macc_program();
        bp_mode = 1'b0;
        check_done_count();

        test_name = "halt";
        run_halt();
        start_lane();
        check_bit("o_steady after restart", 1'b1, o_steady);
        clear_program();
        load_program();
        run_halt();
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
        check_done_count();
        if (ap_seen != 2) begin
            err_main++;
            $display("Fail %s ap_done count expected 2 actual %0d", test_name, ap_seen);
        end

        err_total = err_main + err_sink + err_mon;
        $display("errors %0d (checks %0d, stream %0d, pulses %0d), beats compared %0d",
                 err_total, err_main, err_sink, err_mon, beats);
        if (err_total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/vec_lane_top.sv
`timescale 1ns/1ns
`default_nettype none

module vec_lane_top
    import vec_data_pkg::*, vec_isa_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     i_start,
    input  wire opcode_t  i_opcode,
    input  wire rf_addr_t i_vd,
    input  wire rf_addr_t i_vs,
    input  wire vlen_t    i_vl,
    input  wire phit_t    i_in_data,
    input  wire logic     i_in_valid,
    output logic          o_in_ready,
    output phit_t         o_out_data,
    output logic          o_out_last,
    output logic          o_out_valid,
    input  wire logic     i_out_ready,
    output logic          o_steady,
    output logic          o_instr_done,
    output logic          o_ap_done
);
    phit_t    in_data;
    logic     in_empty;
    logic     in_full;
    logic     in_pop;
    logic     out_push;
    logic     out_last;
    logic     out_empty;
    logic     out_almost_full;
    rf_addr_t rd_addr_a;
    rf_addr_t rd_addr_b;
    phit_t    rd_data_a;
    phit_t    rd_data_b;
    logic     pe_issue;
    pe_op_t   pe_op;
    rf_addr_t pe_addr;
    logic     rf_wr_en;
    rf_addr_t rf_wr_addr;
    phit_t    rf_wr_data;

    assign o_in_ready  = !in_full && o_steady;  // closed outside steady state
    assign o_out_valid = !out_empty;

    stream_fifo u_in_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_push        (i_in_valid && o_in_ready),
        .i_pop         (in_pop),
        .i_data        (i_in_data),
        .i_flag        (1'b0),        // no input last
        .o_data        (in_data),
        .o_flag        (),
        .o_empty       (in_empty),
        .o_full        (in_full),
        .o_almost_full ()
    );

    vec_sequencer u_seq (
        .clk               (clk),
        .rst               (rst),
        .i_start           (i_start),
        .i_opcode          (i_opcode),
        .i_vd              (i_vd),
        .i_vs              (i_vs),
        .i_vl              (i_vl),
        .i_in_empty        (in_empty),
        .i_out_almost_full (out_almost_full),
        .o_in_pop          (in_pop),
        .o_steady          (o_steady),
        .o_rd_addr_a       (rd_addr_a),
        .o_rd_addr_b       (rd_addr_b),
        .o_pe_issue        (pe_issue),
        .o_pe_op           (pe_op),
        .o_wr_addr         (pe_addr),
        .o_out_push        (out_push),
        .o_out_last        (out_last),
        .o_instr_done      (o_instr_done),
        .o_ap_done         (o_ap_done)
    );

    vec_regfile u_rf (
        .clk         (clk),
        .i_rd_addr_a (rd_addr_a),
        .i_rd_addr_b (rd_addr_b),
        .o_rd_data_a (rd_data_a),
        .o_rd_data_b (rd_data_b),
        .i_wr_en     (rf_wr_en),
        .i_wr_addr   (rf_wr_addr),
        .i_wr_data   (rf_wr_data)
    );

    vec_mac_pe u_pe (
        .clk       (clk),
        .rst       (rst),
        .i_issue   (pe_issue),
        .i_op      (pe_op),
        .i_wr_addr (pe_addr),
        .i_in_data (in_data),
        .i_acc     (rd_data_a),
        .i_mul     (rd_data_b),
        .o_wr_en   (rf_wr_en),
        .o_wr_addr (rf_wr_addr),
        .o_wr_data (rf_wr_data)
    );

    // stream-out reads vd through port a
    stream_fifo u_out_fifo (
        .clk           (clk),
        .rst           (rst),
        .i_push        (out_push),
        .i_pop         (o_out_valid && i_out_ready),
        .i_data        (rd_data_a),
        .i_flag        (out_last),
        .o_data        (o_out_data),
        .o_flag        (o_out_last),
        .o_empty       (out_empty),
        .o_full        (),
        .o_almost_full (out_almost_full)
    );

endmodule

`default_nettype wire

//--- hdl/vec_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "vec_lane_config.svh"

module vec_sequencer
    import vec_data_pkg::*, vec_isa_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     i_start,            // loader done pulse
    input  wire opcode_t  i_opcode,
    input  wire rf_addr_t i_vd,
    input  wire rf_addr_t i_vs,
    input  wire vlen_t    i_vl,
    input  wire logic     i_in_empty,
    input  wire logic     i_out_almost_full,
    output logic          o_in_pop,
    output logic          o_steady,
    output rf_addr_t      o_rd_addr_a,        // vd element
    output rf_addr_t      o_rd_addr_b,        // vs element
    output logic          o_pe_issue,
    output pe_op_t        o_pe_op,
    output rf_addr_t      o_wr_addr,
    output logic          o_out_push,
    output logic          o_out_last,
    output logic          o_instr_done,
    output logic          o_ap_done
);
    // one bit per PE stage whose write is still ahead
    localparam int INFL_W = `VL_MAC_LAT - 1;

    seq_state_t        state;
    seq_state_t        state_nxt;
    opcode_t           op_q;
    rf_addr_t          vd_q;
    rf_addr_t          vs_q;
    vlen_t             vl_q;
    vlen_t             cnt;       // element index within the instruction
    logic [INFL_W-1:0] inflight;
    logic              needs_in;
    logic              is_pe;
    logic              is_stream;
    logic              stall;
    logic              go;
    logic              last_elem;

    always_comb begin
        needs_in  = (op_q == OP_VLOAD) || (op_q == OP_VMACC);
        is_pe     = needs_in || (op_q == OP_VCLEAR);
        is_stream = (op_q == OP_VSTREAMOUT);
        case (op_q)
            OP_VLOAD: o_pe_op = PE_LOAD;
            OP_VMACC: o_pe_op = PE_MACC;
            default:  o_pe_op = PE_CLEAR;
        endcase
    end

    // almost full covers the element already read but not yet pushed
    assign stall     = (needs_in && i_in_empty) || (is_stream && i_out_almost_full);
    assign go        = (state == ST_RUN) && !stall;
    assign last_elem = (cnt == vl_q - vlen_t'(1));

    // element k of a register is base + k, wrapping around the file
    assign o_rd_addr_a = vd_q + cnt[RF_AW-1:0];
    assign o_rd_addr_b = vs_q + cnt[RF_AW-1:0];
    assign o_wr_addr   = vd_q + cnt[RF_AW-1:0];

    assign o_pe_issue   = go && is_pe;
    assign o_in_pop     = go && needs_in;
    assign o_steady     = (state != ST_OFF);
    assign o_instr_done = (state == ST_DONE);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_OFF: begin
                if (i_start) begin
                    state_nxt = ST_FETCH;
                end
            end
            ST_FETCH: begin
                if (i_opcode == OP_HALT) begin
                    state_nxt = ST_OFF;
                end else if (i_vl == '0) begin
                    state_nxt = ST_DONE;  // nothing to issue
                end else begin
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                if (go && last_elem) begin
                    state_nxt = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // last PE write or last output push has landed
                if (inflight == '0 && !o_out_push) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: state_nxt = ST_FETCH;
            default: state_nxt = ST_OFF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_OFF;
            cnt        <= '0;
            inflight   <= '0;
            o_ap_done  <= 1'b0;
            o_out_push <= 1'b0;
            o_out_last <= 1'b0;
        end else begin
            state      <= state_nxt;
            o_ap_done  <= (state == ST_FETCH) && (i_opcode == OP_HALT);
            o_out_push <= go && is_stream;  // lines up with the registered read
            o_out_last <= go && is_stream && last_elem;
            inflight   <= (inflight << 1) | INFL_W'(o_pe_issue);
            if (state == ST_FETCH) begin
                cnt <= '0;
            end else if (go) begin
                cnt <= cnt + vlen_t'(1);
            end
        end
    end

    // instruction latch
    always_ff @(posedge clk) begin
        if (state == ST_FETCH) begin
            op_q <= i_opcode;
            vd_q <= i_vd;
            vs_q <= i_vs;
            vl_q <= i_vl;
        end
    end

    vl_nonzero: assert property (@(posedge clk) disable iff (rst)
        (state == ST_FETCH && i_opcode != OP_HALT) |-> (i_vl != '0))
        else $error("vec_sequencer captured vl of zero");

    pop_not_empty: assert property (@(posedge clk) disable iff (rst)
        o_in_pop |-> !i_in_empty)
        else $error("vec_sequencer popped an empty input FIFO");

endmodule

`default_nettype wire

//--- hdl/vec_mac_pe.sv
`timescale 1ns/1ns
`default_nettype none

`include "vec_lane_config.svh"

module vec_mac_pe
    import vec_data_pkg::*, vec_isa_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     i_issue,
    input  wire pe_op_t   i_op,
    input  wire rf_addr_t i_wr_addr,
    input  wire phit_t    i_in_data,   // FIFO head, sampled at issue
    input  wire phit_t    i_acc,       // vd row, one cycle after issue
    input  wire phit_t    i_mul,       // vs row, same timing
    output logic          o_wr_en,
    output rf_addr_t      o_wr_addr,
    output phit_t         o_wr_data
);
    localparam int EW = $bits(elem_t);

    logic     s1_valid;
    logic     s2_valid;
    pe_op_t   s1_op;
    pe_op_t   s2_op;
    rf_addr_t s1_addr;
    rf_addr_t s2_addr;
    phit_t    s1_in;
    phit_t    s2_in;
    phit_t    s2_acc;
    phit_t    s2_prod;

    // valid line, nothing here ever stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_issue;
            s2_valid <= s1_valid;
        end
    end

    // stage 1 takes the input phit, the regfile registers the operands
    // stage 2 multiplies lane by lane, low element bits kept
    always_ff @(posedge clk) begin
        s1_op   <= i_op;
        s1_addr <= i_wr_addr;
        s1_in   <= i_in_data;
        s2_op   <= s1_op;
        s2_addr <= s1_addr;
        s2_in   <= s1_in;
        s2_acc  <= i_acc;
        for (int l = 0; l < `VL_LANES; l++) begin
            s2_prod[l*EW +: EW] <= s1_in[l*EW +: EW] * i_mul[l*EW +: EW];
        end
    end

    // stage 3, result goes straight into the write port
    always_comb begin
        for (int l = 0; l < `VL_LANES; l++) begin
            case (s2_op)
                PE_LOAD: o_wr_data[l*EW +: EW] = s2_in[l*EW +: EW];
                PE_MACC: o_wr_data[l*EW +: EW] = s2_acc[l*EW +: EW] + s2_prod[l*EW +: EW];
                default: o_wr_data[l*EW +: EW] = '0;  // clear
            endcase
        end
    end

    assign o_wr_en   = s2_valid;
    assign o_wr_addr = s2_addr;

    // write lands VL_MAC_LAT edges after the issue cycle
    wr_follows_issue: assert property (@(posedge clk) disable iff (rst)
        o_wr_en |-> $past(i_issue, `VL_MAC_LAT - 1))
        else $error("vec_mac_pe write without a matching issue");

endmodule

`default_nettype wire

//--- hdl/vec_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "vec_lane_config.svh"

module vec_regfile
    import vec_data_pkg::*;
(
    input  wire logic     clk,
    input  wire rf_addr_t i_rd_addr_a,
    input  wire rf_addr_t i_rd_addr_b,
    output phit_t         o_rd_data_a,
    output phit_t         o_rd_data_b,
    input  wire logic     i_wr_en,
    input  wire rf_addr_t i_wr_addr,
    input  wire phit_t    i_wr_data
);
    phit_t rows [`VL_RF_DEPTH];

    // single write port, fed from the PE
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            rows[i_wr_addr] <= i_wr_data;
        end
    end

    // both reads registered, same row as a write gives the old phit
    always_ff @(posedge clk) begin
        o_rd_data_a <= rows[i_rd_addr_a];
        o_rd_data_b <= rows[i_rd_addr_b];
    end

endmodule

`default_nettype wire

//--- hdl/stream_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "vec_lane_config.svh"

module stream_fifo
    import vec_data_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  i_push,
    input  wire logic  i_pop,
    input  wire phit_t i_data,
    input  wire logic  i_flag,
    output phit_t      o_data,
    output logic       o_flag,
    output logic       o_empty,
    output logic       o_full,
    output logic       o_almost_full
);
    localparam int DEPTH = `VL_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [$bits(phit_t):0] mem [DEPTH];  // {flag, phit}
    logic [AW-1:0]          wr_ptr;
    logic [AW-1:0]          rd_ptr;
    logic [AW:0]            count;

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= {i_flag, i_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head entry shows without a pop
    assign {o_flag, o_data} = mem[rd_ptr];

    assign o_empty       = (count == '0);
    assign o_full        = (count == (AW+1)'(DEPTH));
    assign o_almost_full = (count >= (AW+1)'(DEPTH - 1));  // one slot left or none

    no_overflow: assert property (@(posedge clk) disable iff (rst) i_push |-> !o_full)
        else $error("stream_fifo push while full");

    no_underflow: assert property (@(posedge clk) disable iff (rst) i_pop |-> !o_empty)
        else $error("stream_fifo pop while empty");

endmodule

`default_nettype wire

//--- hdl/vec_isa_pkg.sv
`default_nettype none

package vec_isa_pkg;

    // instruction opcodes as presented on i_opcode
    typedef enum logic [2:0] {
        OP_VLOAD      = 3'd0,  // vd[k] <= input phit
        OP_VCLEAR     = 3'd1,  // vd[k] <= 0
        OP_VMACC      = 3'd2,  // vd[k] <= vd[k] + in * vs[k]
        OP_VSTREAMOUT = 3'd3,  // vd[k] -> output stream
        OP_HALT       = 3'd4   // end of program
    } opcode_t;

    // sequencer FSM
    typedef enum logic [2:0] {
        ST_OFF,
        ST_FETCH,
        ST_RUN,
        ST_DRAIN,
        ST_DONE
    } seq_state_t;

    // operation carried down the PE pipe
    typedef enum logic [1:0] {
        PE_LOAD  = 2'd0,
        PE_CLEAR = 2'd1,
        PE_MACC  = 2'd2
    } pe_op_t;

endpackage

`default_nettype wire

//--- hdl/vec_data_pkg.sv
`default_nettype none

`include "vec_lane_config.svh"

package vec_data_pkg;

    localparam int RF_AW = $clog2(`VL_RF_DEPTH);

    // one lane
    typedef logic [`VL_ELEM_W-1:0] elem_t;

    // all lanes, lane 0 in the low bits
    typedef logic [`VL_LANES*`VL_ELEM_W-1:0] phit_t;

    // row of the register file
    typedef logic [RF_AW-1:0] rf_addr_t;

    // element count, needs to hold VL_RF_DEPTH itself
    typedef logic [RF_AW:0] vlen_t;

endpackage

`default_nettype wire

//--- hdl/vec_lane_config.svh
`ifndef VEC_LANE_CONFIG_SVH
`define VEC_LANE_CONFIG_SVH

// lanes packed side by side in one phit
`define VL_LANES 4

// width of one lane element, integer and wrapping
`define VL_ELEM_W 32

// register file rows, shared by all vector registers
`define VL_RF_DEPTH 16

// entries in each stream FIFO, power of two
`define VL_FIFO_DEPTH 16

// issue to register write, in cycles
`define VL_MAC_LAT 3

`endif
